// File: source/spi_cmd_pkg.sv
package spi_cmd_pkg;

  // ####################
  // Command word layout.
  // ####################

  // Full command as the host presents it.
  localparam int CMD_WIDTH = 12;

  // Set for a write, clear for a read.
  localparam int RW_BIT = 11;

  // Register address field.
  localparam int ADDR_MSB = 10;
  localparam int ADDR_LSB = 8;

  // ####################
  // Frame lengths.
  // ####################

  // Write data sits in the low bits and a read result has the same width.
  localparam int DATA_WIDTH = 8;

  // A read sends only the flag and the address before the turnaround.
  localparam int RD_TX_BITS = 4;

endpackage

// File: source/spi_timing_pkg.sv
package spi_timing_pkg;

  // ####################
  // Serial clock.
  // ####################

  // One bit lasts two sclk half periods of this many clk cycles each.
  localparam int DEF_HALF_PERIOD = 4;

  // ####################
  // Read turnaround.
  // ####################

  // clk cycles between the read header and the first data bit.
  // cs stays low and sclk stays idle for the whole gap.
  localparam int DEF_GAP_CYCLES = 16;

endpackage

// File: source/spi_cmd_queue.sv
`timescale 1ns/1ps

module spi_cmd_queue import spi_cmd_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 frame_take,
  output logic                 cmd_rdy,
  output logic [CMD_WIDTH-1:0] frame_cmd,
  output logic                 frame_vld
);

  logic [CMD_WIDTH-1:0] entry [2];
  logic [1:0]           entry_vld;
  logic                 head;
  logic                 tail;
  logic                 push;
  logic                 pop;

  // ####################
  // Handshakes.
  // ####################

  assign cmd_rdy = ~(&entry_vld); // Room while at least one slot is free.
  assign push    = cmd_vld && cmd_rdy;
  assign pop     = frame_take && frame_vld;

  // The oldest entry is always the one offered to the serializer.
  assign frame_vld = entry_vld[head];
  assign frame_cmd = entry[head];

  // ####################
  // Slot bookkeeping.
  // ####################

  // A push needs a free tail slot and a pop needs a full head slot, so the
  // two never touch the same valid bit in one cycle.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      entry_vld <= 2'b00;
      head      <= 1'b0;
      tail      <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        entry_vld[tail] <= 1'b1;
        tail            <= ~tail;
      end
      if (pop)
      begin
        entry_vld[head] <= 1'b0;
        head            <= ~head;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      entry[tail] <= cmd_in;
    end
  end

endmodule

// File: source/spi_serializer.sv
`timescale 1ns/1ps

module spi_serializer import spi_cmd_pkg::*; #(
  parameter int HALF_PERIOD = 1,
  parameter int GAP_CYCLES  = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  frame_cmd,
  input  logic                  frame_vld,
  input  logic                  miso,
  output logic                  frame_take,
  output logic                  frame_busy,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  output logic                  read_vld,
  output logic [DATA_WIDTH-1:0] read_data
);

  localparam int DIV_W = $clog2(2 * HALF_PERIOD);
  localparam int GAP_W = $clog2(GAP_CYCLES + 1);
  localparam int BIT_W = $clog2(CMD_WIDTH);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_GAP,
    ST_RECV,
    ST_FINISH
  } state_t;

  state_t               state;
  logic [DIV_W-1:0]     div_cnt;
  logic [GAP_W-1:0]     gap_cnt;
  logic [BIT_W-1:0]     bit_cnt;
  logic [BIT_W-1:0]     last_tx_bit;
  logic [CMD_WIDTH-1:0] shift_reg;
  logic                 is_read;
  logic                 shifting;
  logic                 rise_tick;
  logic                 fall_tick;

  assign shifting    = (state == ST_SEND) || (state == ST_RECV);
  assign rise_tick   = shifting && (div_cnt == DIV_W'(HALF_PERIOD - 1));
  assign fall_tick   = shifting && (div_cnt == DIV_W'(2 * HALF_PERIOD - 1));
  assign last_tx_bit = is_read ? BIT_W'(RD_TX_BITS - 1) : BIT_W'(CMD_WIDTH - 1);
  assign frame_busy  = frame_take || (state != ST_IDLE);

  // ####################
  // sclk divider.
  // ####################

  // Each bit starts with sclk low, so the divider restarts on every entry.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end
    else if (!shifting)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end
    else
    begin
      div_cnt <= fall_tick ? '0 : div_cnt + 1'b1;
      if (rise_tick)
        sclk <= 1'b1;
      else if (fall_tick)
        sclk <= 1'b0;
    end
  end

  // ####################
  // Frame FSM.
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      gap_cnt    <= '0;
      is_read    <= 1'b0;
      frame_take <= 1'b0;
      cs         <= 1'b1;
      mosi       <= 1'b0;
      read_vld   <= 1'b0;
    end
    else
    begin
      frame_take <= 1'b0;
      read_vld   <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (frame_take) // Head is still on frame_cmd during the pop.
          begin
            is_read <= ~frame_cmd[RW_BIT];
            mosi    <= frame_cmd[CMD_WIDTH-1];
            cs      <= 1'b0;
            bit_cnt <= '0;
            state   <= ST_SEND;
          end
          else if (frame_vld)
          begin
            frame_take <= 1'b1;
          end
        end
        ST_SEND:
        begin
          if (fall_tick && (bit_cnt == last_tx_bit))
          begin
            mosi    <= 1'b0;
            bit_cnt <= '0;
            gap_cnt <= '0;
            state   <= is_read ? ST_GAP : ST_FINISH;
          end
          else if (fall_tick)
          begin
            mosi    <= shift_reg[CMD_WIDTH-2]; // Next bit goes out while sclk is low.
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1))
            state <= ST_RECV;
        end
        ST_RECV:
        begin
          if (fall_tick && (bit_cnt == BIT_W'(DATA_WIDTH - 1)))
            state <= ST_FINISH;
          else if (fall_tick)
            bit_cnt <= bit_cnt + 1'b1;
        end
        ST_FINISH:
        begin
          cs       <= 1'b1;
          read_vld <= is_read;
          state    <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // One register serves both directions. Header bits leave at the top while
  // read data enters at the bottom, so the byte ends up in the low bits.
  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && frame_take)
      shift_reg <= frame_cmd;
    else if ((state == ST_SEND) && fall_tick)
      shift_reg <= shift_reg << 1;
    else if ((state == ST_RECV) && rise_tick)
      shift_reg <= {shift_reg[CMD_WIDTH-2:0], miso};
    if ((state == ST_FINISH) && is_read)
      read_data <= shift_reg[DATA_WIDTH-1:0];
  end

endmodule

// File: source/spi_cmd_master.sv
`timescale 1ns/1ps

module spi_cmd_master import spi_cmd_pkg::*, spi_timing_pkg::*; #(
  parameter int HALF_PERIOD = DEF_HALF_PERIOD,
  parameter int GAP_CYCLES  = DEF_GAP_CYCLES
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  input  logic                  miso,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  output logic                  read_vld,
  output logic [DATA_WIDTH-1:0] read_data
);

  logic [CMD_WIDTH-1:0] frame_cmd;
  logic                 frame_vld;
  logic                 frame_take;
  logic                 frame_busy; // Watched by the bound properties.

  // Two-slot command buffer in front of the serial engine.
  spi_cmd_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .frame_take (frame_take),
    .cmd_rdy    (cmd_rdy),
    .frame_cmd  (frame_cmd),
    .frame_vld  (frame_vld)
  );

  spi_serializer #(
    .HALF_PERIOD (HALF_PERIOD),
    .GAP_CYCLES  (GAP_CYCLES)
  ) u_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_cmd  (frame_cmd),
    .frame_vld  (frame_vld),
    .miso       (miso),
    .frame_take (frame_take),
    .frame_busy (frame_busy),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

endmodule

// File: tests/spi_reg_model.sv
`timescale 1ns/1ps

module spi_reg_model import spi_cmd_pkg::*; (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  localparam int LOG_DEPTH = 128;

  logic [DATA_WIDTH-1:0] regs [8];
  logic [CMD_WIDTH-1:0]  frame_bits [LOG_DEPTH];  // Holds the mosi bits of each cs window.
  int                    frame_rises [LOG_DEPTH];
  int                    frame_count = 0;
  logic [CMD_WIDTH-1:0]  shift_in;
  logic [CMD_WIDTH-1:0]  word;
  int                    rise_cnt = 0;
  logic                  read_mode;
  logic [DATA_WIDTH-1:0] rd_byte;
  logic                  miso_q = 1'b0;

  assign miso = miso_q;
  assign word = {shift_in[CMD_WIDTH-2:0], mosi}; // Includes the bit now on the line.

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = '0;
  end

  // ####################
  // Receive side.
  // ####################

  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      if ((rise_cnt != 0) && (frame_count < LOG_DEPTH))
      begin
        frame_bits[frame_count]  <= shift_in;
        frame_rises[frame_count] <= rise_cnt;
        frame_count              <= frame_count + 1;
      end
      shift_in  <= '0;
      rise_cnt  <= 0;
      read_mode <= 1'b0;
    end
    else
    begin
      shift_in <= word;
      rise_cnt <= rise_cnt + 1;
      // The header is complete on the fourth rise.
      if ((rise_cnt == RD_TX_BITS - 1) && !word[RD_TX_BITS-1])
      begin
        read_mode <= 1'b1;
        rd_byte   <= regs[word[2:0]];
      end
      if ((rise_cnt == CMD_WIDTH - 1) && word[RW_BIT])
        regs[word[ADDR_MSB:ADDR_LSB]] <= word[DATA_WIDTH-1:0];
    end
  end

  // Read data goes out MSB first, each bit changing after an sclk fall.
  always @(negedge sclk or posedge cs)
  begin
    if (cs)
      miso_q <= 1'b0;
    else if (read_mode && (rise_cnt >= RD_TX_BITS) && (rise_cnt < CMD_WIDTH))
      miso_q <= rd_byte[CMD_WIDTH - 1 - rise_cnt];
  end

endmodule

// File: tests/spi_cmd_master_props.sv
`timescale 1ns/1ps

module spi_cmd_master_props (
  input logic clk,
  input logic rst_n,
  input logic cs,
  input logic sclk,
  input logic read_vld,
  input logic cmd_rdy,
  input logic frame_busy
);

  // ####################
  // Bus and host rules.
  // ####################

  sclk_idle_cs_high: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else $error("sclk is high while cs is high.");

  read_vld_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld stayed high for two cycles.");

  cmd_rdy_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(cmd_rdy))
    else $error("cmd_rdy has an unknown value.");

  // The serializer owns the bus for the whole cs-low window.
  busy_in_frame: assert property (@(posedge clk) disable iff (!rst_n) !cs |-> frame_busy)
    else $error("frame_busy is low while cs is low.");

endmodule

bind spi_cmd_master spi_cmd_master_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .cs         (cs),
  .sclk       (sclk),
  .read_vld   (read_vld),
  .cmd_rdy    (cmd_rdy),
  .frame_busy (frame_busy)
);

// File: tests/spi_cmd_master_tb.sv
`timescale 1ns/1ps

module spi_cmd_master_tb import spi_cmd_pkg::*, spi_timing_pkg::*; ();

  localparam int FRAME_CYCLES = 6 + CMD_WIDTH * 2 * DEF_HALF_PERIOD + DEF_GAP_CYCLES;
  localparam int WAIT_LIMIT   = 4 * FRAME_CYCLES;
  localparam int RAND_OPS     = 40;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  miso;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  read_vld;
  logic [DATA_WIDTH-1:0] read_data;
  logic [DATA_WIDTH-1:0] expect_reg [8]; // Last value written to each address.
  logic [DATA_WIDTH-1:0] read_log [128];
  int                    read_count = 0;
  logic [31:0]           rand_state;

  spi_cmd_master #(
    .HALF_PERIOD (DEF_HALF_PERIOD),
    .GAP_CYCLES  (DEF_GAP_CYCLES)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_reg_model slave (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk)
  begin
    if (read_vld && (read_count < 128))
    begin
      read_log[read_count] <= read_data;
      read_count           <= read_count + 1;
    end
  end

  // ####################
  // Helpers.
  // ####################

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [CMD_WIDTH-1:0] write_cmd(input logic [2:0] addr,
                                                     input logic [7:0] data);
    return {1'b1, addr, data};
  endfunction

  function automatic logic [CMD_WIDTH-1:0] read_cmd(input logic [2:0] addr);
    return {1'b0, addr, 8'h00};
  endfunction

  task automatic stop_with_fail();
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_fail();
    end
  endtask

  // Called on a falling edge; returns on the falling edge after acceptance.
  task automatic issue(input logic [CMD_WIDTH-1:0] cmd, output int waited);
    waited  = 0;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("Timed out waiting for cmd_rdy to rise.");
        stop_with_fail();
      end
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_frames(input int target);
    int cycles;
    cycles = 0;
    while (slave.frame_count < target)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        $display("Timed out waiting for an SPI frame to end.");
        stop_with_fail();
      end
    end
    repeat (2) @(negedge clk); // The read monitor settles.
  endtask

  task automatic check_frame(input int idx, input logic [CMD_WIDTH-1:0] cmd);
    if (cmd[RW_BIT])
    begin
      check("sclk rises in write", slave.frame_rises[idx], CMD_WIDTH);
      check("mosi write bits", slave.frame_bits[idx], cmd);
    end
    else
    begin
      check("sclk rises in read", slave.frame_rises[idx], RD_TX_BITS + DATA_WIDTH);
      check("mosi read header", slave.frame_bits[idx][CMD_WIDTH-1 -: RD_TX_BITS],
            cmd[CMD_WIDTH-1 -: RD_TX_BITS]);
    end
  endtask

  task automatic run_write(input logic [2:0] addr, input logic [7:0] data);
    int first;
    int waited;
    first = slave.frame_count;
    issue(write_cmd(addr, data), waited);
    wait_frames(first + 1);
    expect_reg[addr] = data;
    check("cs windows", slave.frame_count, first + 1);
    check_frame(first, write_cmd(addr, data));
    check("slave register", slave.regs[addr], data);
  endtask

  task automatic run_read(input logic [2:0] addr);
    int first;
    int reads;
    int waited;
    first = slave.frame_count;
    reads = read_count;
    issue(read_cmd(addr), waited);
    wait_frames(first + 1);
    check("cs windows", slave.frame_count, first + 1);
    check_frame(first, read_cmd(addr));
    check("read_vld pulses", read_count, reads + 1);
    check("read_data", read_log[reads], expect_reg[addr]);
  endtask

  // ####################
  // Tests.
  // ####################

  task automatic test_reset();
    check("cs", cs, 1'b1);
    check("sclk", sclk, 1'b0);
    check("mosi", mosi, 1'b0);
    check("read_vld", read_vld, 1'b0);
    check("cmd_rdy", cmd_rdy, 1'b1);
  endtask

  task automatic test_write();
    run_write(3'd5, 8'ha7);
  endtask

  task automatic test_read_after_write();
    run_read(3'd5);
  endtask

  // The fourth command has to wait for the first frame to finish.
  task automatic test_pipeline();
    logic [CMD_WIDTH-1:0] cmds [4];
    int                   waits [4];
    int                   first;
    int                   reads;
    int                   done_at_fourth;
    cmds[0] = write_cmd(3'd1, 8'h3c);
    cmds[1] = write_cmd(3'd2, 8'hc3);
    cmds[2] = read_cmd(3'd1);
    cmds[3] = write_cmd(3'd6, 8'h81);
    first   = slave.frame_count;
    reads   = read_count;
    for (int i = 0; i < 4; i++)
      issue(cmds[i], waits[i]);
    done_at_fourth = slave.frame_count - first;
    check("cmd_rdy wait first", waits[0], 0);
    check("cmd_rdy wait second", waits[1], 0);
    check("cmd_rdy low for third", waits[2] > 0, 1'b1);
    check("frames ended before fourth", done_at_fourth, 1);
    wait_frames(first + 4);
    expect_reg[1] = 8'h3c;
    expect_reg[2] = 8'hc3;
    expect_reg[6] = 8'h81;
    for (int i = 0; i < 4; i++)
      check_frame(first + i, cmds[i]);
    check("read_vld pulses", read_count, reads + 1);
    check("read_data", read_log[reads], expect_reg[1]);
  endtask

  task automatic test_random();
    logic [31:0] r;
    for (int i = 0; i < RAND_OPS; i++)
    begin
      rand_state = xorshift(rand_state);
      r          = rand_state;
      if (r[0])
        run_write(r[3:1], r[11:4]);
      else
        run_read(r[3:1]);
    end
  endtask

  initial
  begin
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    rand_state = 32'h2c12;
    for (int i = 0; i < 8; i++)
      expect_reg[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_write();
    test_read_after_write();
    test_pipeline();
    test_random();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: spi_cmd_master.f
source/spi_cmd_pkg.sv
source/spi_timing_pkg.sv
source/spi_cmd_queue.sv
source/spi_serializer.sv
source/spi_cmd_master.sv
tests/spi_reg_model.sv
tests/spi_cmd_master_props.sv
tests/spi_cmd_master_tb.sv
